// ==== filelist.f ====
verilog/arcade_io_pkg.sv
verilog/cabinet_inputs.sv
verilog/dip_switch_loader.sv
verilog/color_dac.sv
verilog/pll_reconfig_seq.sv
verilog/arcade_io_top.sv
verification/tb_arcade_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the arcade I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f filelist.f \
	--top-module tb_arcade_io -Mdir obj_dir -o tb_arcade_io
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_arcade_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	exit 1
fi
exit 0

// ==== verification/tb_arcade_io.sv ====
/*
 * Directed testbench for the arcade cabinet I/O glue.
 * Covers key decode, joystick merge, DIP loading, the colour DAC
 * and the PLL retune sequence, each as its own test task.
 */
module tb_arcade_io;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DIP_BYTES        = arcade_io_pkg::DIP_BYTES_DEFAULT;
	localparam int CLK_PERIOD_NS    = 10;
	localparam int DRIVE_DELAY      = 1;
	localparam int DAC_PIXELS       = 32;
	localparam int PLL_WAIT_LIMIT   = 100;
	localparam int PLL_QUIET_CYCLES = 20;

	// Cycle budget of all tests, then a margin
	localparam int TEST_CYCLES = 16 + 20 + 66 + 33 + 15 + DAC_PIXELS +
	                             2 * (PLL_WAIT_LIMIT + PLL_QUIET_CYCLES);
	localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD_NS;

	logic                    CLK_49M;
	logic                    reset;
	arcade_io_pkg::ps2_key_t ps2_key;
	logic [15:0]             joystick_0;
	logic [15:0]             joystick_1;
	logic                    ioctl_wr;
	logic [7:0]              ioctl_index;
	logic [24:0]             ioctl_addr;
	logic [7:0]              ioctl_dout;
	arcade_io_pkg::rgb5_t    game_rgb;
	logic                    underclock;
	logic                    pll_waitrequest;
	arcade_io_pkg::cabinet_t cabinet;
	logic [8*DIP_BYTES-1:0]  dip_sw;
	arcade_io_pkg::rgb8_t    vga_rgb;
	arcade_io_pkg::pll_cfg_t pll_cfg;

	int          checks = 0;
	int          errors = 0;
	logic [31:0] rng = 32'd20;

	// Levels the active-low switch bank should show
	logic [8*DIP_BYTES-1:0] dip_model;

	arcade_io_top #(
		.DIP_BYTES (DIP_BYTES)
	) UUT (
		.CLK_49M         (CLK_49M),
		.reset           (reset),
		.ps2_key         (ps2_key),
		.joystick_0      (joystick_0),
		.joystick_1      (joystick_1),
		.ioctl_wr        (ioctl_wr),
		.ioctl_index     (ioctl_index),
		.ioctl_addr      (ioctl_addr),
		.ioctl_dout      (ioctl_dout),
		.game_rgb        (game_rgb),
		.underclock      (underclock),
		.pll_waitrequest (pll_waitrequest),
		.cabinet         (cabinet),
		.dip_sw          (dip_sw),
		.vga_rgb         (vga_rgb),
		.pll_cfg         (pll_cfg)
	);

	initial begin
		CLK_49M = 1'b0;
		forever #(CLK_PERIOD_NS / 2) CLK_49M = ~CLK_49M;
	end

	// ==================================================
	// Helpers
	// ==================================================

	// Edge, then the drive point
	task automatic next_cycle();
		@(posedge CLK_49M);
		#(DRIVE_DELAY);
	endtask

	task automatic compare(input string name, input logic [63:0] expected,
	                       input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error: %s expected %h got %h", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Key order matches the held-button vector of the model
	function automatic logic [7:0] key_at(input int i);
		case (i)
			0:       return arcade_io_pkg::KEY_START1;
			1:       return arcade_io_pkg::KEY_START2;
			2:       return arcade_io_pkg::KEY_COIN1;
			3:       return arcade_io_pkg::KEY_COIN2;
			4:       return arcade_io_pkg::KEY_SERVICE;
			5:       return arcade_io_pkg::KEY_PAUSE;
			6:       return arcade_io_pkg::KEY_UP;
			7:       return arcade_io_pkg::KEY_DOWN;
			8:       return arcade_io_pkg::KEY_LEFT;
			9:       return arcade_io_pkg::KEY_RIGHT;
			default: return arcade_io_pkg::KEY_FIRE;
		endcase
	endfunction

	// Expected cabinet word from held keys and both pads
	function automatic arcade_io_pkg::cabinet_t model_cabinet(input logic [10:0] held,
			input logic [15:0] j0, input logic [15:0] j1);
		arcade_io_pkg::cabinet_t active;
		logic [15:0] either;
		either = j0 | j1;
		active.coin    = {held[3], held[2] | either[arcade_io_pkg::JOY_COIN1]};
		active.start   = {held[1] | either[arcade_io_pkg::JOY_START2],
		                  held[0] | either[arcade_io_pkg::JOY_START1]};
		active.p1_joy  = {held[9] | j0[arcade_io_pkg::JOY_RIGHT],
		                  held[8] | j0[arcade_io_pkg::JOY_LEFT],
		                  held[7] | j0[arcade_io_pkg::JOY_DOWN],
		                  held[6] | j0[arcade_io_pkg::JOY_UP]};
		active.p2_joy  = {held[9] | j1[arcade_io_pkg::JOY_RIGHT],
		                  held[8] | j1[arcade_io_pkg::JOY_LEFT],
		                  held[7] | j1[arcade_io_pkg::JOY_DOWN],
		                  held[6] | j1[arcade_io_pkg::JOY_UP]};
		active.p1_fire = held[10] | j0[arcade_io_pkg::JOY_FIRE];
		active.p2_fire = held[10] | j1[arcade_io_pkg::JOY_FIRE];
		active.service = held[4];
		active.pause   = held[5] | either[arcade_io_pkg::JOY_PAUSE];
		return arcade_io_pkg::cabinet_t'(~active);
	endfunction

	// Resistor ladder, bit 0 weight first
	function automatic logic [7:0] ladder_level(input logic [4:0] level);
		logic [7:0] weights [5];
		logic [7:0] total;
		weights = '{8'h19, 8'h24, 8'h35, 8'h40, 8'h4D};
		total = 8'h00;
		for (int i = 0; i < 5; i++) begin
			if (level[i])
				total = total + weights[i];
		end
		return total;
	endfunction

	task automatic send_key(input logic [7:0] code, input logic pressed);
		ps2_key.toggle   = ~ps2_key.toggle;
		ps2_key.pressed  = pressed;
		ps2_key.extended = 1'b0;
		ps2_key.code     = code;
	endtask

	// One download write, stored on the next edge
	task automatic dip_write(input logic [7:0] index, input int addr, input logic [7:0] data);
		ioctl_wr    = 1'b1;
		ioctl_index = index;
		ioctl_addr  = 25'(addr);
		ioctl_dout  = data;
		next_cycle();
		ioctl_wr    = 1'b0;
	endtask

	// ==================================================
	// Tests
	// ==================================================

	task automatic after_reset();
		int stray;
		stray = 0;
		compare("cabinet", 64'hFFFF, 64'(cabinet));
		compare("dip_sw", 64'hFFFF, 64'(dip_sw));
		compare("vga_rgb", 64'h0, 64'(vga_rgb));
		repeat (20) begin
			next_cycle();
			if (pll_cfg.write)
				stray++;
		end
		compare("pll_cfg.write count", 64'd0, 64'(stray));
	endtask

	task automatic key_events();
		for (int i = 0; i < 11; i++) begin
			send_key(key_at(i), 1'b1);
			repeat (3) next_cycle();
			compare("cabinet", 64'(model_cabinet(11'h001 << i, 16'h0, 16'h0)), 64'(cabinet));
			send_key(key_at(i), 1'b0);
			repeat (3) next_cycle();
			compare("cabinet", 64'(model_cabinet(11'h000, 16'h0, 16'h0)), 64'(cabinet));
		end
	endtask

	// Walk a single bit across each pad in turn
	task automatic joystick_inputs();
		for (int b = 0; b < 16; b++) begin
			joystick_0 = 16'h0001 << b;
			joystick_1 = 16'h0000;
			next_cycle();
			compare("cabinet", 64'(model_cabinet(11'h000, joystick_0, joystick_1)),
			        64'(cabinet));
		end
		for (int b = 0; b < 16; b++) begin
			joystick_0 = 16'h0000;
			joystick_1 = 16'h0001 << b;
			next_cycle();
			compare("cabinet", 64'(model_cabinet(11'h000, joystick_0, joystick_1)),
			        64'(cabinet));
		end
		joystick_1 = 16'h0000;
		next_cycle();
		compare("cabinet", 64'hFFFF, 64'(cabinet));
	endtask

	task automatic dip_loading();
		logic [7:0] b0;
		logic [7:0] b1;
		for (int round = 0; round < 3; round++) begin
			rng = xorshift32(rng);
			b0  = rng[7:0];
			b1  = rng[15:8];
			dip_write(arcade_io_pkg::DIP_INDEX, 0, b0);
			dip_model[7:0] = ~b0;
			compare("dip_sw", 64'(dip_model), 64'(dip_sw));
			dip_write(arcade_io_pkg::DIP_INDEX, 1, b1);
			dip_model[15:8] = ~b1;
			compare("dip_sw", 64'(dip_model), 64'(dip_sw));
			// Wrong index, then out of range, must be ignored
			dip_write(8'd253, 0, ~b0);
			compare("dip_sw", 64'(dip_model), 64'(dip_sw));
			dip_write(arcade_io_pkg::DIP_INDEX, 2, ~b1);
			compare("dip_sw", 64'(dip_model), 64'(dip_sw));
			dip_write(arcade_io_pkg::DIP_INDEX, 2 + 37 * round, b0 ^ b1);
			compare("dip_sw", 64'(dip_model), 64'(dip_sw));
		end
	endtask

	// New pixel every clock, checked one edge later
	task automatic dac_levels();
		arcade_io_pkg::rgb5_t sent;
		arcade_io_pkg::rgb8_t expected;
		for (int k = 0; k < DAC_PIXELS; k++) begin
			rng  = xorshift32(rng);
			sent = arcade_io_pkg::rgb5_t'(rng[14:0]);
			if (k == DAC_PIXELS - 1)
				sent = '1;
			game_rgb = sent;
			next_cycle();
			expected.r = ladder_level(sent.r);
			expected.g = ladder_level(sent.g);
			expected.b = ladder_level(sent.b);
			compare("vga_rgb", 64'(expected), 64'(vga_rgb));
		end
		// Full scale on every channel
		compare("vga_rgb", 64'h00FFFFFF, 64'(vga_rgb));
	endtask

	task automatic pll_retune(input logic value, input logic [31:0] frac);
		logic [5:0]  addr_seen [3];
		logic [31:0] data_seen [3];
		int writes;
		int cycles;
		int extra;
		writes = 0;
		cycles = 0;
		extra  = 0;
		underclock = value;
		while (writes < 3 && cycles < PLL_WAIT_LIMIT) begin
			next_cycle();
			cycles++;
			// Busy every fourth cycle
			pll_waitrequest = ((cycles % 4) == 2);
			if (pll_cfg.write) begin
				addr_seen[writes] = pll_cfg.address;
				data_seen[writes] = pll_cfg.data;
				writes++;
			end
		end
		pll_waitrequest = 1'b0;
		if (writes < 3) begin
			errors++;
			$display("PLL retune to %0d gave only %0d writes in %0d cycles",
			         value, writes, PLL_WAIT_LIMIT);
		end else begin
			compare("pll_cfg.address", 64'(arcade_io_pkg::PLL_REG_MODE), 64'(addr_seen[0]));
			compare("pll_cfg.data", 64'd0, 64'(data_seen[0]));
			compare("pll_cfg.address", 64'(arcade_io_pkg::PLL_REG_FRAC), 64'(addr_seen[1]));
			compare("pll_cfg.data", 64'(frac), 64'(data_seen[1]));
			compare("pll_cfg.address", 64'(arcade_io_pkg::PLL_REG_START), 64'(addr_seen[2]));
			compare("pll_cfg.data", 64'd0, 64'(data_seen[2]));
		end
		// Nothing may follow the start write
		repeat (PLL_QUIET_CYCLES) begin
			next_cycle();
			if (pll_cfg.write)
				extra++;
		end
		compare("pll_cfg.write count", 64'd0, 64'(extra));
	endtask

	// ==================================================
	// Sequence and watchdog
	// ==================================================
	initial begin
		reset           = 1'b1;
		ps2_key         = '0;
		joystick_0      = 16'h0000;
		joystick_1      = 16'h0000;
		ioctl_wr        = 1'b0;
		ioctl_index     = 8'h00;
		ioctl_addr      = 25'h0;
		ioctl_dout      = 8'h00;
		game_rgb        = '0;
		underclock      = 1'b0;
		pll_waitrequest = 1'b0;
		dip_model       = '1;
		repeat (16) @(posedge CLK_49M);
		#(DRIVE_DELAY);
		reset = 1'b0;

		after_reset();
		key_events();
		joystick_inputs();
		dip_loading();
		dac_levels();
		pll_retune(1'b1, arcade_io_pkg::PLL_FRAC_UNDER);
		pll_retune(1'b0, arcade_io_pkg::PLL_FRAC_NATIVE);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== verilog/arcade_io_pkg.sv ====
/*
 * Shared types and constants for the arcade cabinet I/O glue.
 * Covers PS/2 key events, joystick bit positions, the active-low
 * cabinet input bundle, colour words, DIP download settings and
 * the PLL management-bus retune values.
 */
package arcade_io_pkg;

	// ==================================================
	// Keyboard and joystick
	// ==================================================

	// Toggle flips once per key event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	// Set 2 scan codes used by the cabinet
	typedef enum logic [7:0] {
		KEY_FIRE    = 8'h14,
		KEY_START1  = 8'h16,
		KEY_START2  = 8'h1E,
		KEY_COIN1   = 8'h2E,
		KEY_COIN2   = 8'h36,
		KEY_SERVICE = 8'h46,
		KEY_PAUSE   = 8'h4D,
		KEY_LEFT    = 8'h6B,
		KEY_DOWN    = 8'h72,
		KEY_RIGHT   = 8'h74,
		KEY_UP      = 8'h75
	} key_code_t;

	// Bit positions in the 16-bit joystick word
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE   = 4;
	localparam int JOY_START1 = 5;
	localparam int JOY_COIN1  = 6;
	localparam int JOY_START2 = 7;
	localparam int JOY_PAUSE  = 8;

	// Game inputs, all active low
	typedef struct packed {
		logic [1:0] coin;    // coin2, coin1
		logic [1:0] start;   // start2, start1
		logic [3:0] p1_joy;  // right, left, down, up
		logic [3:0] p2_joy;
		logic       p1_fire;
		logic       p2_fire;
		logic       service;
		logic       pause;
	} cabinet_t;

	// ==================================================
	// Video and downloads
	// ==================================================

	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} rgb5_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb8_t;

	// Resistor ladder weights, bit 0 in the low byte
	localparam logic [4:0][7:0] DAC_WEIGHTS = {8'h4D, 8'h40, 8'h35, 8'h24, 8'h19};

	localparam logic [7:0] DIP_INDEX         = 8'd254;
	localparam int         DIP_BYTES_DEFAULT = 2;

	// ==================================================
	// PLL reconfiguration
	// ==================================================

	// One management-bus write
	typedef struct packed {
		logic        write;
		logic [5:0]  address;
		logic [31:0] data;
	} pll_cfg_t;

	typedef enum logic [2:0] {
		STEP_IDLE,
		STEP_MODE,
		STEP_GAP1,
		STEP_GAP2,
		STEP_GAP3,
		STEP_FRAC,
		STEP_GAP4,
		STEP_START
	} cfg_step_t;

	localparam logic [5:0]  PLL_REG_MODE    = 6'd0;
	localparam logic [5:0]  PLL_REG_FRAC    = 6'd7;
	localparam logic [5:0]  PLL_REG_START   = 6'd2;
	localparam logic [31:0] PLL_FRAC_NATIVE = 32'd3639383488;
	localparam logic [31:0] PLL_FRAC_UNDER  = 32'd3262113561;

endpackage

// ==== verilog/arcade_io_top.sv ====
/*
 * Cabinet-side glue for the vertical shooter.
 * Wires the control inputs, DIP loader, colour DAC and PLL
 * retune sequencer, all on the single CLK_49M domain.
 */
module arcade_io_top #(
	parameter int DIP_BYTES = arcade_io_pkg::DIP_BYTES_DEFAULT
) (
	input  logic                    CLK_49M,
	input  logic                    reset,
	// Controls
	input  arcade_io_pkg::ps2_key_t ps2_key,
	input  logic [15:0]             joystick_0,
	input  logic [15:0]             joystick_1,
	// Download stream
	input  logic                    ioctl_wr,
	input  logic [7:0]              ioctl_index,
	input  logic [24:0]             ioctl_addr,
	input  logic [7:0]              ioctl_dout,
	// Video from the game
	input  arcade_io_pkg::rgb5_t    game_rgb,
	// PLL control
	input  logic                    underclock,
	input  logic                    pll_waitrequest,
	output arcade_io_pkg::cabinet_t cabinet,
	output logic [8*DIP_BYTES-1:0]  dip_sw,
	output arcade_io_pkg::rgb8_t    vga_rgb,
	output arcade_io_pkg::pll_cfg_t pll_cfg
);

	// ==================================================
	// Controls and switches
	// ==================================================
	cabinet_inputs u_cabinet_inputs (
		.CLK_49M    (CLK_49M),
		.reset      (reset),
		.ps2_key    (ps2_key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.cabinet    (cabinet)
	);

	dip_switch_loader #(
		.DIP_BYTES (DIP_BYTES)
	) u_dip_switch_loader (
		.CLK_49M     (CLK_49M),
		.reset       (reset),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dip_sw      (dip_sw)
	);

	// ==================================================
	// Video and clocking
	// ==================================================
	color_dac u_color_dac (
		.CLK_49M  (CLK_49M),
		.reset    (reset),
		.game_rgb (game_rgb),
		.vga_rgb  (vga_rgb)
	);

	pll_reconfig_seq u_pll_reconfig_seq (
		.CLK_49M         (CLK_49M),
		.reset           (reset),
		.underclock      (underclock),
		.pll_waitrequest (pll_waitrequest),
		.pll_cfg         (pll_cfg)
	);

endmodule

// ==== verilog/cabinet_inputs.sv ====
/*
 * Keyboard and joystick front end for the cabinet controls.
 * Holds arcade button state from PS/2 key events, merges it with
 * both joysticks and registers the result as active-low inputs.
 */
module cabinet_inputs (
	input  logic                    CLK_49M,
	input  logic                    reset,
	input  arcade_io_pkg::ps2_key_t ps2_key,
	input  logic [15:0]             joystick_0,
	input  logic [15:0]             joystick_1,
	output arcade_io_pkg::cabinet_t cabinet
);

	// Previous toggle, for edge detection
	logic old_toggle;

	// Held keyboard buttons, active high
	logic btn_up, btn_down, btn_left, btn_right, btn_fire;
	logic btn_start1, btn_start2, btn_coin1, btn_coin2;
	logic btn_service, btn_pause;

	// Either joystick
	logic [15:0] joy_any;

	arcade_io_pkg::cabinet_t merged;

	// ==================================================
	// Key event decode
	// ==================================================
	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			// Track the current toggle so reset release is not an event
			old_toggle  <= ps2_key.toggle;
			btn_up      <= 1'b0;
			btn_down    <= 1'b0;
			btn_left    <= 1'b0;
			btn_right   <= 1'b0;
			btn_fire    <= 1'b0;
			btn_start1  <= 1'b0;
			btn_start2  <= 1'b0;
			btn_coin1   <= 1'b0;
			btn_coin2   <= 1'b0;
			btn_service <= 1'b0;
			btn_pause   <= 1'b0;
		end else begin
			old_toggle <= ps2_key.toggle;
			if (old_toggle != ps2_key.toggle) begin
				// One event, one button
				case (ps2_key.code)
					arcade_io_pkg::KEY_START1:  btn_start1  <= ps2_key.pressed;
					arcade_io_pkg::KEY_START2:  btn_start2  <= ps2_key.pressed;
					arcade_io_pkg::KEY_COIN1:   btn_coin1   <= ps2_key.pressed;
					arcade_io_pkg::KEY_COIN2:   btn_coin2   <= ps2_key.pressed;
					arcade_io_pkg::KEY_SERVICE: btn_service <= ps2_key.pressed;
					arcade_io_pkg::KEY_PAUSE:   btn_pause   <= ps2_key.pressed;
					arcade_io_pkg::KEY_UP:      btn_up      <= ps2_key.pressed;
					arcade_io_pkg::KEY_DOWN:    btn_down    <= ps2_key.pressed;
					arcade_io_pkg::KEY_LEFT:    btn_left    <= ps2_key.pressed;
					arcade_io_pkg::KEY_RIGHT:   btn_right   <= ps2_key.pressed;
					arcade_io_pkg::KEY_FIRE:    btn_fire    <= ps2_key.pressed;
					default: ;
				endcase
			end
		end
	end

	// ==================================================
	// Merge with joysticks
	// ==================================================
	assign joy_any = joystick_0 | joystick_1;

	always_comb begin
		// Player 1 controls
		merged.p1_joy  = {btn_right | joystick_0[arcade_io_pkg::JOY_RIGHT],
		                  btn_left  | joystick_0[arcade_io_pkg::JOY_LEFT],
		                  btn_down  | joystick_0[arcade_io_pkg::JOY_DOWN],
		                  btn_up    | joystick_0[arcade_io_pkg::JOY_UP]};
		merged.p1_fire = btn_fire | joystick_0[arcade_io_pkg::JOY_FIRE];
		// Player 2 shares the keyboard
		merged.p2_joy  = {btn_right | joystick_1[arcade_io_pkg::JOY_RIGHT],
		                  btn_left  | joystick_1[arcade_io_pkg::JOY_LEFT],
		                  btn_down  | joystick_1[arcade_io_pkg::JOY_DOWN],
		                  btn_up    | joystick_1[arcade_io_pkg::JOY_UP]};
		merged.p2_fire = btn_fire | joystick_1[arcade_io_pkg::JOY_FIRE];
		// Start, coin and pause from any pad
		merged.start   = {btn_start2 | joy_any[arcade_io_pkg::JOY_START2],
		                  btn_start1 | joy_any[arcade_io_pkg::JOY_START1]};
		merged.coin    = {btn_coin2, btn_coin1 | joy_any[arcade_io_pkg::JOY_COIN1]};
		merged.pause   = btn_pause | joy_any[arcade_io_pkg::JOY_PAUSE];
		// Keyboard only
		merged.service = btn_service;
	end

	// Active low, registered
	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			cabinet <= '1;
		end else begin
			cabinet <= ~merged;
		end
	end

endmodule

// ==== verilog/color_dac.sv ====
/*
 * Colour output stage modelling the board's resistor ladder.
 * Each 5-bit channel becomes an 8-bit intensity, the sum of the
 * ladder weights of its set bits, with one cycle of latency.
 */
module color_dac (
	input  logic                 CLK_49M,
	input  logic                 reset,
	input  arcade_io_pkg::rgb5_t game_rgb,
	output arcade_io_pkg::rgb8_t vga_rgb
);

	// Weighted sum for one channel
	function automatic logic [7:0] ladder(input logic [4:0] level);
		logic [7:0] sum;
		sum = 8'h00;
		for (int i = 0; i < 5; i++) begin
			if (level[i])
				sum = sum + arcade_io_pkg::DAC_WEIGHTS[i];
		end
		return sum;
	endfunction

	arcade_io_pkg::rgb8_t weighted;

	always_comb begin
		weighted.r = ladder(game_rgb.r);
		weighted.g = ladder(game_rgb.g);
		weighted.b = ladder(game_rgb.b);
	end

	// New pixel every clock
	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			vga_rgb <= '0;
		end else begin
			vga_rgb <= weighted;
		end
	end

endmodule

// ==== verilog/dip_switch_loader.sv ====
/*
 * DIP switch bank loaded from the download stream.
 * Bytes written at the DIP index are stored by address and
 * presented inverted as the active-low switch inputs of the game.
 */
module dip_switch_loader #(
	parameter int DIP_BYTES = arcade_io_pkg::DIP_BYTES_DEFAULT
) (
	input  logic                   CLK_49M,
	input  logic                   reset,
	input  logic                   ioctl_wr,
	input  logic [7:0]             ioctl_index,
	input  logic [24:0]            ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	output logic [8*DIP_BYTES-1:0] dip_sw
);

	// Stored bytes, byte 0 lowest
	logic [DIP_BYTES-1:0][7:0] dip_bytes;

	// Write aimed at the DIP bank
	logic dip_hit;

	assign dip_hit = ioctl_wr && (ioctl_index == arcade_io_pkg::DIP_INDEX) &&
	                 (ioctl_addr < 25'(DIP_BYTES));

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			dip_bytes <= '0;
		end else if (dip_hit) begin
			for (int i = 0; i < DIP_BYTES; i++) begin
				if (ioctl_addr == 25'(i))
					dip_bytes[i] <= ioctl_dout;
			end
		end
	end

	// Switch bank is active low
	assign dip_sw = ~dip_bytes;

endmodule

// ==== verilog/pll_reconfig_seq.sv ====
/*
 * PLL retune sequencer for the 60 Hz underclock option.
 * A settled change of the underclock bit issues three management
 * writes (mode, fractional divider, start) paced by wait-request.
 */
module pll_reconfig_seq (
	input  logic                    CLK_49M,
	input  logic                    reset,
	input  logic                    underclock,
	input  logic                    pll_waitrequest,
	output arcade_io_pkg::pll_cfg_t pll_cfg
);

	// Two-stage synchronizer
	logic uc_meta, uc_sync;

	// Setting the PLL currently runs at
	logic uc_applied;

	arcade_io_pkg::cfg_step_t step;

	// Write strobe and payload
	logic        cfg_write;
	logic [5:0]  cfg_address;
	logic [31:0] cfg_data;

	logic start_seq;

	// Stable new value seen
	assign start_seq = (uc_sync == uc_meta) && (uc_sync != uc_applied);

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			uc_meta    <= 1'b0;
			uc_sync    <= 1'b0;
			uc_applied <= 1'b0;
			step       <= arcade_io_pkg::STEP_IDLE;
			cfg_write  <= 1'b0;
		end else begin
			uc_meta   <= underclock;
			uc_sync   <= uc_meta;
			cfg_write <= 1'b0;

			if (start_seq) begin
				step       <= arcade_io_pkg::STEP_MODE;
				uc_applied <= uc_sync;
			end

			// Hold while the bus is busy
			if (!pll_waitrequest) begin
				// STEP_START wraps back to idle
				if (step != arcade_io_pkg::STEP_IDLE)
					step <= arcade_io_pkg::cfg_step_t'(step + 3'd1);
				case (step)
					arcade_io_pkg::STEP_MODE: begin
						cfg_write   <= 1'b1;
						cfg_address <= arcade_io_pkg::PLL_REG_MODE;
						cfg_data    <= 32'd0;
					end
					arcade_io_pkg::STEP_FRAC: begin
						cfg_write   <= 1'b1;
						cfg_address <= arcade_io_pkg::PLL_REG_FRAC;
						cfg_data    <= uc_applied ? arcade_io_pkg::PLL_FRAC_UNDER :
						                            arcade_io_pkg::PLL_FRAC_NATIVE;
					end
					arcade_io_pkg::STEP_START: begin
						cfg_write   <= 1'b1;
						cfg_address <= arcade_io_pkg::PLL_REG_START;
						cfg_data    <= 32'd0;
					end
					default: ;
				endcase
			end
		end
	end

	assign pll_cfg.write   = cfg_write;
	assign pll_cfg.address = cfg_address;
	assign pll_cfg.data    = cfg_data;

endmodule
